/* rtl/ifetch_settings.svh */
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// address and instruction widths
`define IFETCH_ADDR_W 32
`define IFETCH_DATA_W 32

// cache geometry, direct mapped
`define IFETCH_LINES      4
`define IFETCH_LINE_WORDS 2

// first fetch address after reset
`define IFETCH_PC_INIT 32'h8000_0000

// rv32 opcodes that end sequential fetch
`define IFETCH_OP_JAL    7'b1101111
`define IFETCH_OP_JALR   7'b1100111
`define IFETCH_OP_BRANCH 7'b1100011
`define IFETCH_OP_SYSTEM 7'b1110011

// fence.i with rd, rs1 and imm all zero
`define IFETCH_INST_FENCE_I 32'h0000_100f

`endif

/* rtl/ifetch_pkg.sv */
`include "ifetch_settings.svh"

package ifetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // vector types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`IFETCH_ADDR_W-1:0] addr_t;
  typedef logic [`IFETCH_DATA_W-1:0] inst_t;

  typedef logic [$clog2(`IFETCH_LINES)-1:0] index_t;

  // whatever is left above the line index, the word select and the byte offset
  typedef logic [`IFETCH_ADDR_W-$clog2(`IFETCH_LINES)-$clog2(`IFETCH_LINE_WORDS)-3:0] tag_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    addr_t pc;
  } fetch_req_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_rsp_t;

  typedef struct packed {
    addr_t addr;
  } bus_ar_t;

  typedef struct packed {
    inst_t data;
  } bus_r_t;

  // refill walks both words of a line, low word first
  typedef enum logic [1:0] {
    IDLE,
    READ_LO,
    WAIT_HI,
    READ_HI
  } refill_state_t;

endpackage

/* rtl/fetch_pc.sv */
`timescale 1ns/1ns
`include "ifetch_settings.svh"

module fetch_pc (
  input  logic                   clk,
  input  logic                   rst,

  output logic                   req_valid_o,
  output ifetch_pkg::fetch_req_t req_o,
  input  logic                   req_ready_i,

  input  logic                   rsp_fire_i,
  input  ifetch_pkg::fetch_rsp_t rsp_i,

  input  logic                   redirect_valid_i,
  input  ifetch_pkg::addr_t      redirect_pc_i,
  output logic                   redirect_ready_o
);

  typedef enum logic {
    FETCH,
    STALL
  } pc_state_t;

  pc_state_t         state_q;
  ifetch_pkg::addr_t pc_q;
  logic              req_valid_q;
  logic              busy_q;

  logic [6:0]        opcode;
  logic              is_ctrl;
  logic              req_fire;
  logic              redirect_fire;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // predecode of the instruction that just left
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign opcode = rsp_i.inst[6:0];

  // the back end resolves these, so fetch waits for its target
  assign is_ctrl = (opcode == `IFETCH_OP_JAL)    ||
                   (opcode == `IFETCH_OP_JALR)   ||
                   (opcode == `IFETCH_OP_BRANCH) ||
                   (opcode == `IFETCH_OP_SYSTEM);

  assign req_fire      = req_valid_q && req_ready_i;
  assign redirect_fire = redirect_valid_i && redirect_ready_o;

  assign req_valid_o      = req_valid_q;
  assign req_o.pc         = pc_q;
  assign redirect_ready_o = (state_q == STALL);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pc and request sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= FETCH;
      pc_q        <= `IFETCH_PC_INIT;
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
    end
    else
    begin
      // only one request is ever outstanding
      if (req_fire)
      begin
        req_valid_q <= 1'b0;
        busy_q      <= 1'b1;
      end
      else if ((state_q == FETCH) && !busy_q && !req_valid_q)
      begin
        req_valid_q <= 1'b1;
      end

      if (rsp_fire_i)
      begin
        busy_q <= 1'b0;
        if (is_ctrl)
        begin
          state_q <= STALL;
        end
        else
        begin
          pc_q <= rsp_i.pc + ifetch_pkg::addr_t'(4);
        end
      end

      // the next request goes out one cycle after the target lands
      if (redirect_fire)
      begin
        pc_q    <= redirect_pc_i;
        state_q <= FETCH;
      end
    end
  end

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ns
`include "ifetch_settings.svh"

module icache (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   req_valid_i,
  input  ifetch_pkg::fetch_req_t req_i,
  output logic                   req_ready_o,

  output logic                   rsp_valid_o,
  output ifetch_pkg::fetch_rsp_t rsp_o,
  input  logic                   rsp_ready_i,

  output logic                   bus_ar_valid_o,
  output ifetch_pkg::bus_ar_t    bus_ar_o,
  input  logic                   bus_ar_ready_i,

  input  logic                   bus_r_valid_i,
  input  ifetch_pkg::bus_r_t     bus_r_i,
  output logic                   bus_r_ready_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ifetch_pkg::inst_t         data_q [`IFETCH_LINES][`IFETCH_LINE_WORDS];
  ifetch_pkg::tag_t          tag_q [`IFETCH_LINES];
  logic [`IFETCH_LINES-1:0]  valid_q;

  ifetch_pkg::refill_state_t state_q;
  ifetch_pkg::addr_t         req_pc_q;
  ifetch_pkg::fetch_rsp_t    rsp_q;
  logic                      rsp_valid_q;
  logic                      ar_valid_q;

  // address split of the incoming request
  ifetch_pkg::tag_t          lkp_tag;
  ifetch_pkg::index_t        lkp_idx;
  logic                      lkp_word;

  // address split of the request being refilled
  ifetch_pkg::tag_t          rq_tag;
  ifetch_pkg::index_t        rq_idx;
  logic                      rq_word;

  logic                      hit;
  logic                      req_fire;
  logic                      rsp_fire;
  logic                      ar_fire;
  logic                      r_fire;
  logic                      is_fence_i;

  assign {lkp_tag, lkp_idx, lkp_word} = req_i.pc[`IFETCH_ADDR_W-1:2];
  assign {rq_tag, rq_idx, rq_word}    = req_pc_q[`IFETCH_ADDR_W-1:2];

  assign hit = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);

  assign req_ready_o = (state_q == ifetch_pkg::IDLE) && !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_q && rsp_ready_i;
  assign ar_fire     = ar_valid_q && bus_ar_ready_i;
  assign r_fire      = bus_r_valid_i && bus_r_ready_o;

  assign is_fence_i = (rsp_q.inst == `IFETCH_INST_FENCE_I);

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // byte offset is always zero, the word select picks low or high beat
  assign bus_ar_valid_o = ar_valid_q;
  assign bus_ar_o.addr  = {rq_tag, rq_idx, (state_q == ifetch_pkg::READ_HI), 2'b00};

  // a beat is only taken once its address has gone out
  assign bus_r_ready_o = ((state_q == ifetch_pkg::READ_LO) ||
                          (state_q == ifetch_pkg::READ_HI)) && !ar_valid_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // refill state machine and valid bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= ifetch_pkg::IDLE;
      valid_q     <= '0;
      rsp_valid_q <= 1'b0;
      ar_valid_q  <= 1'b0;
    end
    else
    begin
      if (rsp_fire)
      begin
        rsp_valid_q <= 1'b0;
        // code may have been rewritten, so every line goes
        if (is_fence_i)
        begin
          valid_q <= '0;
        end
      end

      if (ar_fire)
      begin
        ar_valid_q <= 1'b0;
      end

      case (state_q)
        ifetch_pkg::IDLE:
        begin
          if (req_fire)
          begin
            if (hit)
            begin
              rsp_valid_q <= 1'b1;
            end
            else
            begin
              state_q    <= ifetch_pkg::READ_LO;
              ar_valid_q <= 1'b1;
            end
          end
        end
        ifetch_pkg::READ_LO:
        begin
          if (r_fire)
          begin
            // the line is half old, half new until the high beat lands
            valid_q[rq_idx] <= 1'b0;
            state_q         <= ifetch_pkg::WAIT_HI;
          end
        end
        ifetch_pkg::WAIT_HI:
        begin
          state_q    <= ifetch_pkg::READ_HI;
          ar_valid_q <= 1'b1;
        end
        ifetch_pkg::READ_HI:
        begin
          if (r_fire)
          begin
            valid_q[rq_idx] <= 1'b1;
            rsp_valid_q     <= 1'b1;
            state_q         <= ifetch_pkg::IDLE;
          end
        end
        default:
        begin
          state_q <= ifetch_pkg::IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data, tags and response payload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      req_pc_q   <= req_i.pc;
      rsp_q.pc   <= req_i.pc;
      rsp_q.inst <= data_q[lkp_idx][lkp_word];
    end

    if (r_fire && (state_q == ifetch_pkg::READ_LO))
    begin
      data_q[rq_idx][0] <= bus_r_i.data;
      tag_q[rq_idx]     <= rq_tag;
    end

    // the requested word comes straight from the beat or from the low half
    if (r_fire && (state_q == ifetch_pkg::READ_HI))
    begin
      data_q[rq_idx][1] <= bus_r_i.data;
      rsp_q.inst        <= rq_word ? bus_r_i.data : data_q[rq_idx][0];
    end
  end

endmodule

/* rtl/ifetch_top.sv */
`timescale 1ns/1ns

module ifetch_top (
  input  logic                   clk,
  input  logic                   rst,

  // instruction stream to the back end
  output logic                   inst_valid_o,
  output ifetch_pkg::fetch_rsp_t inst_o,
  input  logic                   inst_ready_i,

  // resolved target after a control-flow instruction
  input  logic                   redirect_valid_i,
  input  ifetch_pkg::addr_t      redirect_pc_i,
  output logic                   redirect_ready_o,

  output logic                   bus_ar_valid_o,
  output ifetch_pkg::bus_ar_t    bus_ar_o,
  input  logic                   bus_ar_ready_i,
  input  logic                   bus_r_valid_i,
  input  ifetch_pkg::bus_r_t     bus_r_i,
  output logic                   bus_r_ready_o
);

  logic                   req_valid;
  logic                   req_ready;
  ifetch_pkg::fetch_req_t req;
  logic                   rsp_fire;

  // fetch_pc learns which instruction left from the same handshake
  assign rsp_fire = inst_valid_o && inst_ready_i;

  fetch_pc u_fetch_pc (
    .clk              (clk),
    .rst              (rst),
    .req_valid_o      (req_valid),
    .req_o            (req),
    .req_ready_i      (req_ready),
    .rsp_fire_i       (rsp_fire),
    .rsp_i            (inst_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .redirect_ready_o (redirect_ready_o)
  );

  icache u_icache (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (inst_valid_o),
    .rsp_o          (inst_o),
    .rsp_ready_i    (inst_ready_i),
    .bus_ar_valid_o (bus_ar_valid_o),
    .bus_ar_o       (bus_ar_o),
    .bus_ar_ready_i (bus_ar_ready_i),
    .bus_r_valid_i  (bus_r_valid_i),
    .bus_r_i        (bus_r_i),
    .bus_r_ready_o  (bus_r_ready_o)
  );

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ns

module mem_model (
  input  logic                clk,
  input  logic                rst,
  input  logic                ar_valid_i,
  input  ifetch_pkg::bus_ar_t ar_i,
  output logic                ar_ready_o,
  output logic                r_valid_o,
  output ifetch_pkg::bus_r_t  r_o,
  input  logic                r_ready_i,
  output ifetch_pkg::addr_t   ar_count_o
);

  // program image, loaded by the testbench through the hierarchy
  ifetch_pkg::inst_t mem_q [64];

  ifetch_pkg::addr_t addr_q;
  logic [31:0]       lcg_q;
  logic [1:0]        delay_q;
  logic              data_phase_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // each address and each beat waits 0 to 3 extra cycles
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ar_ready_o   <= 1'b0;
      r_valid_o    <= 1'b0;
      r_o          <= '0;
      ar_count_o   <= '0;
      addr_q       <= '0;
      lcg_q        <= 32'hd1a7_637d;
      delay_q      <= 2'd0;
      data_phase_q <= 1'b0;
    end
    else if (!data_phase_q)
    begin
      if (ar_valid_i && ar_ready_o)
      begin
        ar_ready_o   <= 1'b0;
        addr_q       <= ar_i.addr;
        ar_count_o   <= ar_count_o + 32'd1;
        lcg_q        <= lcg_next(lcg_q);
        delay_q      <= lcg_q[31:30];
        data_phase_q <= 1'b1;
      end
      else if (ar_valid_i && (delay_q == 2'd0))
        ar_ready_o <= 1'b1;
      else if (ar_valid_i)
        delay_q <= delay_q - 2'd1;
    end
    else
    begin
      if (r_valid_o && r_ready_i)
      begin
        r_valid_o    <= 1'b0;
        lcg_q        <= lcg_next(lcg_q);
        delay_q      <= lcg_q[31:30];
        data_phase_q <= 1'b0;
      end
      else if (!r_valid_o && (delay_q == 2'd0))
      begin
        r_valid_o <= 1'b1;
        r_o.data  <= mem_q[addr_q[7:2]];
      end
      else if (!r_valid_o)
        delay_q <= delay_q - 2'd1;
    end
  end

endmodule

/* bench/ifetch_tb.sv */
`timescale 1ns/1ns
`include "ifetch_settings.svh"

module ifetch_tb;

  localparam int TIMEOUT = 60;

  // one row per instruction that the back end should receive
  typedef struct packed {
    ifetch_pkg::addr_t pc;
    ifetch_pkg::inst_t inst;
    int                hold;
    logic              redirect;
    ifetch_pkg::addr_t target;
    logic              patch;
    ifetch_pkg::addr_t patch_addr;
    ifetch_pkg::inst_t patch_data;
    ifetch_pkg::addr_t ar_count;
  } step_t;

  logic                   clk;
  logic                   rst;
  logic                   inst_valid;
  ifetch_pkg::fetch_rsp_t inst;
  logic                   inst_ready;
  logic                   redirect_valid;
  ifetch_pkg::addr_t      redirect_pc;
  logic                   redirect_ready;
  logic                   ar_valid;
  ifetch_pkg::bus_ar_t    ar;
  logic                   ar_ready;
  logic                   r_valid;
  ifetch_pkg::bus_r_t     r;
  logic                   r_ready;
  ifetch_pkg::addr_t      ar_count;

  ifetch_pkg::addr_t      cur_pc;
  ifetch_pkg::addr_t      exp_ar_addr;
  ifetch_pkg::inst_t      image [64];
  step_t                  steps [$];

  ifetch_top UUT (
    .clk              (clk),
    .rst              (rst),
    .inst_valid_o     (inst_valid),
    .inst_o           (inst),
    .inst_ready_i     (inst_ready),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .redirect_ready_o (redirect_ready),
    .bus_ar_valid_o   (ar_valid),
    .bus_ar_o         (ar),
    .bus_ar_ready_i   (ar_ready),
    .bus_r_valid_i    (r_valid),
    .bus_r_i          (r),
    .bus_r_ready_o    (r_ready)
  );

  mem_model u_mem (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .r_ready_i  (r_ready),
    .ar_count_o (ar_count)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // program image and expectation table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic ifetch_pkg::inst_t addi_word(input logic [11:0] imm);
    return {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};
  endfunction

  // sequential words carry their own offset so that every word differs
  function automatic ifetch_pkg::inst_t prog_word(input logic [7:0] off);
    case (off)
      8'h0c:   return {25'd0, `IFETCH_OP_BRANCH};
      8'h10:   return {25'd0, `IFETCH_OP_JAL};
      8'h18:   return `IFETCH_INST_FENCE_I;
      8'h1c:   return {25'd0, `IFETCH_OP_JALR};
      8'h44:   return {25'd0, `IFETCH_OP_SYSTEM};
      default: return addi_word({4'h5, off});
    endcase
  endfunction

  task automatic add_step(input ifetch_pkg::addr_t off, input int hold, input logic redirect,
                          input ifetch_pkg::addr_t target, input ifetch_pkg::addr_t ar);
    step_t s;
    s          = '0;
    s.pc       = `IFETCH_PC_INIT + off;
    s.inst     = image[off[7:2]];
    s.hold     = hold;
    s.redirect = redirect;
    s.target   = `IFETCH_PC_INIT + target;
    s.ar_count = ar;
    steps.push_back(s);
  endtask

  // memory is rewritten while fetch waits for the redirect of the last row
  task automatic patch_last(input ifetch_pkg::addr_t off, input ifetch_pkg::inst_t data);
    step_t s;
    s            = steps.pop_back();
    s.patch      = 1'b1;
    s.patch_addr = off;
    s.patch_data = data;
    steps.push_back(s);
    image[off[7:2]] = data;
  endtask

  task automatic build_table;
    add_step(32'h00, 0, 1'b0, 32'h00, 32'd2);
    add_step(32'h04, 0, 1'b0, 32'h00, 32'd2);
    add_step(32'h08, 5, 1'b0, 32'h00, 32'd4);
    add_step(32'h0c, 0, 1'b1, 32'h00, 32'd4);
    // lines 0 and 1 are resident so the loop costs no reads
    add_step(32'h00, 0, 1'b0, 32'h00, 32'd4);
    add_step(32'h04, 2, 1'b0, 32'h00, 32'd4);
    add_step(32'h08, 0, 1'b0, 32'h00, 32'd4);
    add_step(32'h0c, 0, 1'b1, 32'h10, 32'd4);
    add_step(32'h10, 0, 1'b1, 32'h40, 32'd6);
    // same index as line 0 under another tag
    add_step(32'h40, 0, 1'b0, 32'h00, 32'd8);
    add_step(32'h44, 0, 1'b1, 32'h18, 32'd8);
    patch_last(32'h08, addi_word(12'h7ff));
    add_step(32'h18, 3, 1'b0, 32'h00, 32'd10);
    add_step(32'h1c, 0, 1'b1, 32'h08, 32'd12);
    add_step(32'h08, 0, 1'b0, 32'h00, 32'd14);
    add_step(32'h0c, 0, 1'b1, 32'h00, 32'd14);
    add_step(32'h00, 0, 1'b0, 32'h00, 32'd16);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks and waits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run;
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input ifetch_pkg::fetch_rsp_t got,
                           input ifetch_pkg::fetch_rsp_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got pc %h inst %h, expected pc %h inst %h",
               $time, name, got.pc, got.inst, exp.pc, exp.inst);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input ifetch_pkg::addr_t got,
                            input ifetch_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic wait_inst_valid;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!inst_valid)
    begin
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("no instruction was handed out for pc %h before the timeout", cur_pc);
        stop_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_redirect_ready;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!redirect_ready)
    begin
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("the redirect channel never became ready after pc %h", cur_pc);
        stop_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic watch_backpressure(input step_t step);
    ifetch_pkg::fetch_rsp_t held;
    held.pc   = step.pc;
    held.inst = step.inst;
    for (int k = 0; k < step.hold; k++)
    begin
      @(negedge clk);
      if (!inst_valid)
      begin
        $display("inst_valid_o dropped while inst_ready_i was low at pc %h", step.pc);
        stop_run();
      end
      check_rsp("inst_o", inst, held);
      check_addr("ar count", ar_count, step.ar_count);
    end
  endtask

  task automatic expect_stall(input step_t step);
    repeat (3)
    begin
      @(negedge clk);
      if (inst_valid)
      begin
        $display("pc %h was handed out before the redirect after pc %h", inst.pc, step.pc);
        stop_run();
      end
    end
    if (step.patch)
      u_mem.mem_q[step.patch_addr[7:2]] = step.patch_data;
  endtask

  // every read address must name the current line, low word first
  always @(negedge clk)
  begin
    if (!rst && ar_valid && ar_ready)
    begin
      exp_ar_addr = {cur_pc[31:3], ar_count[0], 2'b00};
      check_addr("bus_ar_o.addr", ar.addr, exp_ar_addr);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // back end
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    step_t                  step;
    ifetch_pkg::fetch_rsp_t exp_rsp;

    rst            <= 1'b1;
    inst_ready     <= 1'b0;
    redirect_valid <= 1'b0;
    redirect_pc    <= '0;
    cur_pc          = `IFETCH_PC_INIT;

    for (int i = 0; i < 64; i++)
    begin
      image[i]       = prog_word(8'(i * 4));
      u_mem.mem_q[i] = image[i];
    end
    build_table();

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < steps.size(); i++)
    begin
      step         = steps[i];
      cur_pc       = step.pc;
      inst_ready  <= (step.hold == 0);
      wait_inst_valid();
      exp_rsp.pc   = step.pc;
      exp_rsp.inst = step.inst;
      check_rsp("inst_o", inst, exp_rsp);
      check_addr("ar count", ar_count, step.ar_count);
      if (step.hold != 0)
      begin
        watch_backpressure(step);
        @(posedge clk);
        inst_ready <= 1'b1;
      end
      // the response leaves on this edge
      @(posedge clk);
      if (step.redirect)
      begin
        expect_stall(step);
        @(posedge clk);
        redirect_pc    <= step.target;
        redirect_valid <= 1'b1;
        wait_redirect_ready();
        @(posedge clk);
        redirect_valid <= 1'b0;
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* ifetch.f */
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/fetch_pc.sv
rtl/icache.sv
rtl/ifetch_top.sv
bench/mem_model.sv
bench/ifetch_tb.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --top-module ifetch_tb -f ifetch.f
	./obj_dir/Vifetch_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
